/* soc_pkg.sv */
package soc_pkg;

	// ====================
	// Bus geometry
	// ====================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int REGION_W = 4;
	localparam int OFFSET_W = ADDR_W - REGION_W;
	localparam int BYTE_W = 2;
	localparam int WORD_IDX_W = 5;
	localparam int UPPER_W = ADDR_W - WORD_IDX_W - BYTE_W;
	localparam int REG_IDX_W = 2;

	// Write when rw is high
	localparam logic BUS_WRITE = 1'b1;

	// Address step between consecutive words
	localparam logic [ADDR_W-1:0] WORD_BYTES = 4;

	// Region map, top nibble of the address
	localparam logic [REGION_W-1:0] REGION_RAM = 4'd1;
	localparam logic [REGION_W-1:0] REGION_DMA = 4'd9;
	localparam logic [REGION_W-1:0] REGION_TIMER = 4'd10;

	// Block RAM
	localparam int RAM_WORDS = 4096;
	localparam int RAM_ADDR_W = 12;

	// ====================
	// Register indexes
	// ====================
	localparam logic [REG_IDX_W-1:0] DMA_REG_SRC = 2'd0;
	localparam logic [REG_IDX_W-1:0] DMA_REG_DST = 2'd1;
	localparam logic [REG_IDX_W-1:0] DMA_REG_COUNT = 2'd2;
	localparam logic [REG_IDX_W-1:0] DMA_REG_CTRL = 2'd3;

	localparam logic [REG_IDX_W-1:0] TMR_REG_CTRL = 2'd0;
	localparam logic [REG_IDX_W-1:0] TMR_REG_COMPARE = 2'd1;
	localparam logic [REG_IDX_W-1:0] TMR_REG_COUNT = 2'd2;
	localparam logic [REG_IDX_W-1:0] TMR_REG_STATUS = 2'd3;

	// DMA copy states
	localparam int DMA_ST_W = 3;
	localparam logic [DMA_ST_W-1:0] DMA_IDLE = 3'd0;
	localparam logic [DMA_ST_W-1:0] DMA_READ = 3'd1;
	localparam logic [DMA_ST_W-1:0] DMA_READ_GAP = 3'd2;
	localparam logic [DMA_ST_W-1:0] DMA_WRITE = 3'd3;
	localparam logic [DMA_ST_W-1:0] DMA_WRITE_GAP = 3'd4;

	// One bus address, seen as region/offset or as a register word
	typedef union packed {
		struct packed {
			logic [REGION_W-1:0] region;
			logic [OFFSET_W-1:0] offset;
		} map;
		struct packed {
			logic [UPPER_W-1:0] upper;
			logic [WORD_IDX_W-1:0] word;
			logic [BYTE_W-1:0] byte_sel;
		} regs;
	} bus_addr_u;

endpackage

/* bus_interconnect.sv */
`timescale 1ns/1ps

module bus_interconnect (
	input  logic                       clock,
	input  logic                       i_rst_n,

	// Instruction fetch, read only
	input  logic                       i_fetch_request,
	input  soc_pkg::bus_addr_u         i_fetch_address,
	output logic                       o_fetch_ready,
	output logic [soc_pkg::DATA_W-1:0] o_fetch_rdata,

	// Data port
	input  logic                       i_data_request,
	input  logic                       i_data_rw,
	input  soc_pkg::bus_addr_u         i_data_address,
	input  logic [soc_pkg::DATA_W-1:0] i_data_wdata,
	output logic                       o_data_ready,
	output logic [soc_pkg::DATA_W-1:0] o_data_rdata,

	// DMA port
	input  logic                       i_dma_request,
	input  logic                       i_dma_rw,
	input  soc_pkg::bus_addr_u         i_dma_address,
	input  logic [soc_pkg::DATA_W-1:0] i_dma_wdata,
	output logic                       o_dma_ready,
	output logic [soc_pkg::DATA_W-1:0] o_dma_rdata,

	// Toward the slaves
	output logic                       o_ram_request,
	output logic                       o_dma_reg_request,
	output logic                       o_timer_request,
	output logic                       o_bus_rw,
	output soc_pkg::bus_addr_u         o_bus_address,
	output logic [soc_pkg::DATA_W-1:0] o_bus_wdata,
	input  logic [soc_pkg::DATA_W-1:0] i_ram_rdata,
	input  logic                       i_ram_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_dma_reg_rdata,
	input  logic                       i_dma_reg_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_timer_rdata,
	input  logic                       i_timer_ready
);
	import soc_pkg::*;

	logic grant_data;
	logic grant_fetch;
	logic grant_dma;
	logic resting;
	logic bus_busy;

	logic sel_rw;
	bus_addr_u sel_address;
	logic [DATA_W-1:0] sel_wdata;

	logic hit_ram;
	logic hit_dma;
	logic hit_timer;
	logic hit_none;
	logic none_ready;

	logic bus_ready;
	logic [DATA_W-1:0] bus_rdata;

	// ====================
	// Arbiter
	// ====================
	assign bus_busy = grant_data || grant_fetch || grant_dma;

	// Fixed priority, data first, then fetch, then DMA
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			grant_data <= 1'b0;
			grant_fetch <= 1'b0;
			grant_dma <= 1'b0;
			resting <= 1'b0;
		end
		else if (bus_busy)
		begin
			if (bus_ready)
			begin
				grant_data <= 1'b0;
				grant_fetch <= 1'b0;
				grant_dma <= 1'b0;
				resting <= 1'b1;
			end
		end
		else if (resting)
			resting <= 1'b0;
		else
		begin
			grant_data <= i_data_request;
			grant_fetch <= i_fetch_request && !i_data_request;
			grant_dma <= i_dma_request && !i_data_request && !i_fetch_request;
		end
	end

	// Granted master drives the shared bus
	always_comb
	begin
		sel_rw = ~BUS_WRITE;
		sel_address = i_fetch_address;
		sel_wdata = '0;
		if (grant_data)
		begin
			sel_rw = i_data_rw;
			sel_address = i_data_address;
			sel_wdata = i_data_wdata;
		end
		else if (grant_dma)
		begin
			sel_rw = i_dma_rw;
			sel_address = i_dma_address;
			sel_wdata = i_dma_wdata;
		end
	end

	assign o_bus_rw = sel_rw;
	assign o_bus_address = sel_address;
	assign o_bus_wdata = sel_wdata;

	// ====================
	// Region decode
	// ====================
	assign hit_ram = sel_address.map.region == REGION_RAM;
	assign hit_dma = sel_address.map.region == REGION_DMA;
	assign hit_timer = sel_address.map.region == REGION_TIMER;
	assign hit_none = !(hit_ram || hit_dma || hit_timer);

	assign o_ram_request = bus_busy && hit_ram;
	assign o_dma_reg_request = bus_busy && hit_dma;
	assign o_timer_request = bus_busy && hit_timer;

	// Unmapped regions answer like a one-cycle slave
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			none_ready <= 1'b0;
		else
			none_ready <= bus_busy && hit_none && !none_ready;
	end

	always_comb
	begin
		if (hit_ram)
		begin
			bus_ready = i_ram_ready;
			bus_rdata = i_ram_rdata;
		end
		else if (hit_dma)
		begin
			bus_ready = i_dma_reg_ready;
			bus_rdata = i_dma_reg_rdata;
		end
		else if (hit_timer)
		begin
			bus_ready = i_timer_ready;
			bus_rdata = i_timer_rdata;
		end
		else
		begin
			bus_ready = none_ready;
			bus_rdata = '0;
		end
	end

	// Response goes to the granted port only
	assign o_data_ready = grant_data && bus_ready;
	assign o_fetch_ready = grant_fetch && bus_ready;
	assign o_dma_ready = grant_dma && bus_ready;
	assign o_data_rdata = grant_data ? bus_rdata : '0;
	assign o_fetch_rdata = grant_fetch ? bus_rdata : '0;
	assign o_dma_rdata = grant_dma ? bus_rdata : '0;

endmodule

/* block_ram.sv */
`timescale 1ns/1ps

module block_ram (
	input  logic                       clock,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  soc_pkg::bus_addr_u         i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic                       o_ready
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [RAM_WORDS];

	logic [UPPER_W+WORD_IDX_W-1:0] word_addr;
	logic [RAM_ADDR_W-1:0] index;
	logic access;

	// Word address, upper bits fold back onto the array
	assign word_addr = {i_address.regs.upper, i_address.regs.word};
	assign index = word_addr[RAM_ADDR_W-1:0];

	// Only the first cycle of a request touches the array
	assign access = i_request && !o_ready;

	always_ff @(posedge clock)
	begin
		o_ready <= access;
	end

	// Read-first port
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			o_rdata <= mem[index];
			if (i_rw == BUS_WRITE)
				mem[index] <= i_wdata;
		end
	end

endmodule

/* dma_engine.sv */
`timescale 1ns/1ps

module dma_engine (
	input  logic                       clock,
	input  logic                       i_rst_n,

	// Register side
	input  logic                       i_request,
	input  logic                       i_rw,
	input  soc_pkg::bus_addr_u         i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic                       o_ready,

	// Bus master side
	output logic                       o_bus_request,
	output logic                       o_bus_rw,
	output soc_pkg::bus_addr_u         o_bus_address,
	output logic [soc_pkg::DATA_W-1:0] o_bus_wdata,
	input  logic                       i_bus_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_bus_rdata
);
	import soc_pkg::*;

	logic [DMA_ST_W-1:0] state;
	logic [ADDR_W-1:0] src_addr;
	logic [ADDR_W-1:0] dst_addr;
	logic [DATA_W-1:0] word_count;
	logic [DATA_W-1:0] data_buf;

	logic [REG_IDX_W-1:0] reg_idx;
	logic access;
	logic reg_write;
	logic busy;

	assign reg_idx = i_address.regs.word[REG_IDX_W-1:0];
	assign access = i_request && !o_ready;
	assign reg_write = access && (i_rw == BUS_WRITE);
	assign busy = state != DMA_IDLE;

	// Request is held only in the two access states
	assign o_bus_request = (state == DMA_READ) || (state == DMA_WRITE);
	assign o_bus_rw = (state == DMA_WRITE) ? BUS_WRITE : ~BUS_WRITE;
	assign o_bus_address = (state == DMA_WRITE) ? dst_addr : src_addr;
	assign o_bus_wdata = data_buf;

	// ====================
	// Registers and copy FSM
	// ====================
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= DMA_IDLE;
			src_addr <= '0;
			dst_addr <= '0;
			word_count <= '0;
			o_ready <= 1'b0;
		end
		else
		begin
			o_ready <= access;
			case (state)
				DMA_IDLE:
				begin
					// Register file only writable while idle
					if (reg_write)
					begin
						case (reg_idx)
							DMA_REG_SRC: src_addr <= i_wdata;
							DMA_REG_DST: dst_addr <= i_wdata;
							DMA_REG_COUNT: word_count <= i_wdata;
							DMA_REG_CTRL:
							begin
								if (i_wdata[0] && word_count != '0)
									state <= DMA_READ;
							end
						endcase
					end
				end
				DMA_READ:
				begin
					if (i_bus_ready)
						state <= DMA_READ_GAP;
				end
				// request drops for a cycle between accesses
				DMA_READ_GAP: state <= DMA_WRITE;
				DMA_WRITE:
				begin
					if (i_bus_ready)
					begin
						src_addr <= src_addr + WORD_BYTES;
						dst_addr <= dst_addr + WORD_BYTES;
						word_count <= word_count - 1'b1;
						state <= DMA_WRITE_GAP;
					end
				end
				DMA_WRITE_GAP: state <= (word_count == '0) ? DMA_IDLE : DMA_READ;
				default: state <= DMA_IDLE;
			endcase
		end
	end

	// Word in flight
	always_ff @(posedge clock)
	begin
		if (state == DMA_READ && i_bus_ready)
			data_buf <= i_bus_rdata;
	end

	// Register readback, busy in CTRL bit 0
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			case (reg_idx)
				DMA_REG_SRC: o_rdata <= src_addr;
				DMA_REG_DST: o_rdata <= dst_addr;
				DMA_REG_COUNT: o_rdata <= word_count;
				DMA_REG_CTRL: o_rdata <= {{(DATA_W-1){1'b0}}, busy};
			endcase
		end
	end

endmodule

/* interval_timer.sv */
`timescale 1ns/1ps

module interval_timer (
	input  logic                       clock,
	input  logic                       i_rst_n,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  soc_pkg::bus_addr_u         i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic                       o_ready,
	output logic                       o_interrupt
);
	import soc_pkg::*;

	logic run_en;
	logic irq_en;
	logic pending;
	logic [DATA_W-1:0] compare;
	logic [DATA_W-1:0] count;

	logic [REG_IDX_W-1:0] reg_idx;
	logic access;
	logic reg_write;

	assign reg_idx = i_address.regs.word[REG_IDX_W-1:0];
	assign access = i_request && !o_ready;
	assign reg_write = access && (i_rw == BUS_WRITE);

	assign o_interrupt = pending && irq_en;

	// ====================
	// Control and counter
	// ====================
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			run_en <= 1'b0;
			irq_en <= 1'b0;
			pending <= 1'b0;
			compare <= '0;
			count <= '0;
			o_ready <= 1'b0;
		end
		else
		begin
			o_ready <= access;
			// CTRL bit 0 runs the counter, bit 1 unmasks the interrupt
			if (reg_write && reg_idx == TMR_REG_CTRL)
			begin
				run_en <= i_wdata[0];
				irq_en <= i_wdata[1];
			end
			if (reg_write && reg_idx == TMR_REG_COMPARE)
				compare <= i_wdata;
			// Write one to clear
			if (reg_write && reg_idx == TMR_REG_STATUS && i_wdata[0])
				pending <= 1'b0;
			// A match in the same cycle still wins
			if (run_en)
			begin
				if (count == compare)
				begin
					count <= '0;
					pending <= 1'b1;
				end
				else
					count <= count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (access)
		begin
			case (reg_idx)
				TMR_REG_CTRL: o_rdata <= {{(DATA_W-2){1'b0}}, irq_en, run_en};
				TMR_REG_COMPARE: o_rdata <= compare;
				TMR_REG_COUNT: o_rdata <= count;
				TMR_REG_STATUS: o_rdata <= {{(DATA_W-1){1'b0}}, pending};
			endcase
		end
	end

endmodule

/* soc_top.sv */
`timescale 1ns/1ps

module soc_top (
	input  logic                       clock,
	input  logic                       i_rst_n,

	// Instruction fetch master
	input  logic                       i_fetch_request,
	input  soc_pkg::bus_addr_u         i_fetch_address,
	output logic                       o_fetch_ready,
	output logic [soc_pkg::DATA_W-1:0] o_fetch_rdata,

	// Data master
	input  logic                       i_data_request,
	input  logic                       i_data_rw,
	input  soc_pkg::bus_addr_u         i_data_address,
	input  logic [soc_pkg::DATA_W-1:0] i_data_wdata,
	output logic                       o_data_ready,
	output logic [soc_pkg::DATA_W-1:0] o_data_rdata,

	output logic                       o_interrupt
);
	import soc_pkg::*;

	// Slave side of the bus
	logic bus_rw;
	bus_addr_u bus_address;
	logic [DATA_W-1:0] bus_wdata;

	logic ram_request;
	logic [DATA_W-1:0] ram_rdata;
	logic ram_ready;

	logic dma_reg_request;
	logic [DATA_W-1:0] dma_reg_rdata;
	logic dma_reg_ready;

	logic timer_request;
	logic [DATA_W-1:0] timer_rdata;
	logic timer_ready;

	// DMA as a third master
	logic dma_bus_request;
	logic dma_bus_rw;
	bus_addr_u dma_bus_address;
	logic [DATA_W-1:0] dma_bus_wdata;
	logic [DATA_W-1:0] dma_bus_rdata;
	logic dma_bus_ready;

	// ====================

	bus_interconnect bus (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_fetch_request(i_fetch_request),
		.i_fetch_address(i_fetch_address),
		.o_fetch_ready(o_fetch_ready),
		.o_fetch_rdata(o_fetch_rdata),
		.i_data_request(i_data_request),
		.i_data_rw(i_data_rw),
		.i_data_address(i_data_address),
		.i_data_wdata(i_data_wdata),
		.o_data_ready(o_data_ready),
		.o_data_rdata(o_data_rdata),
		.i_dma_request(dma_bus_request),
		.i_dma_rw(dma_bus_rw),
		.i_dma_address(dma_bus_address),
		.i_dma_wdata(dma_bus_wdata),
		.o_dma_ready(dma_bus_ready),
		.o_dma_rdata(dma_bus_rdata),
		.o_ram_request(ram_request),
		.o_dma_reg_request(dma_reg_request),
		.o_timer_request(timer_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_ram_rdata(ram_rdata),
		.i_ram_ready(ram_ready),
		.i_dma_reg_rdata(dma_reg_rdata),
		.i_dma_reg_ready(dma_reg_ready),
		.i_timer_rdata(timer_rdata),
		.i_timer_ready(timer_ready)
	);

	block_ram ram (
		.clock(clock),
		.i_request(ram_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	dma_engine dma (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_request(dma_reg_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(dma_reg_rdata),
		.o_ready(dma_reg_ready),
		.o_bus_request(dma_bus_request),
		.o_bus_rw(dma_bus_rw),
		.o_bus_address(dma_bus_address),
		.o_bus_wdata(dma_bus_wdata),
		.i_bus_ready(dma_bus_ready),
		.i_bus_rdata(dma_bus_rdata)
	);

	interval_timer timer (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_request(timer_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_interrupt(o_interrupt)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock
);

	// 20 ns period
	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;
	end

endmodule

/* tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int BUS_TIMEOUT = 100;
	localparam int DMA_POLL_LIMIT = 200;
	localparam int SEED = 19;

	logic clock;
	logic i_rst_n;
	logic i_fetch_request;
	logic [ADDR_W-1:0] i_fetch_address;
	logic o_fetch_ready;
	logic [DATA_W-1:0] o_fetch_rdata;
	logic i_data_request;
	logic i_data_rw;
	logic [ADDR_W-1:0] i_data_address;
	logic [DATA_W-1:0] i_data_wdata;
	logic o_data_ready;
	logic [DATA_W-1:0] o_data_rdata;
	logic o_interrupt;

	// Cleared while the DMA shares the bus
	logic latency_armed;
	int error_count;
	int tests_run;
	int errors_at_start;
	logic [DATA_W-1:0] ram_model [int];
	int written_idx [$];

	tb_clock_gen clock_source (
		.clock(clock)
	);

	soc_top dut (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_fetch_request(i_fetch_request),
		.i_fetch_address(i_fetch_address),
		.o_fetch_ready(o_fetch_ready),
		.o_fetch_rdata(o_fetch_rdata),
		.i_data_request(i_data_request),
		.i_data_rw(i_data_rw),
		.i_data_address(i_data_address),
		.i_data_wdata(i_data_wdata),
		.o_data_ready(o_data_ready),
		.o_data_rdata(o_data_rdata),
		.o_interrupt(o_interrupt)
	);

	// ====================
	// Reporting helpers
	// ====================
	task automatic flag_violation(input string what);
		error_count++;
		$display("Check failed at %0t ns: %s", $time, what);
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] expected);
		if (got !== expected)
		begin
			error_count++;
			$display("FAIL at %0t ns: %s got 0x%08h, expected 0x%08h", $time, name, got,
				expected);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("Timeout at %0t ns: %s", $time, reason);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("%s check done with %0d errors", name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	// ====================
	// Handshake assertions
	// ====================
	// Request and fields hold until ready
	assert property (@(posedge clock) disable iff (!i_rst_n)
		(i_data_request && !o_data_ready) |=> (i_data_request && $stable(i_data_rw)
		&& $stable(i_data_address) && $stable(i_data_wdata)))
	else flag_violation("data port request or fields changed before ready");

	assert property (@(posedge clock) disable iff (!i_rst_n)
		(i_fetch_request && !o_fetch_ready) |=> (i_fetch_request
		&& $stable(i_fetch_address)))
	else flag_violation("fetch port request or address changed before ready");

	assert property (@(posedge clock) disable iff (!i_rst_n)
		o_data_ready |=> !i_data_request)
	else flag_violation("data port request still high after ready");

	assert property (@(posedge clock) disable iff (!i_rst_n)
		o_fetch_ready |=> !i_fetch_request)
	else flag_violation("fetch port request still high after ready");

	assert property (@(posedge clock) !i_data_request |-> !o_data_ready)
	else flag_violation("data port ready high without a request");

	assert property (@(posedge clock) !i_fetch_request |-> !o_fetch_ready)
	else flag_violation("fetch port ready high without a request");

	// Idle bus answers two cycles after the request is seen
	assert property (@(posedge clock) disable iff (!i_rst_n)
		($rose(i_data_request) && !i_fetch_request && latency_armed)
		|=> !o_data_ready ##1 o_data_ready)
	else flag_violation("data port ready did not come 2 cycles after request");

	assert property (@(posedge clock) disable iff (!i_rst_n)
		($rose(i_fetch_request) && !i_data_request && latency_armed)
		|=> !o_fetch_ready ##1 o_fetch_ready)
	else flag_violation("fetch port ready did not come 2 cycles after request");

	// ====================
	// Bus access tasks
	// ====================
	task automatic data_access(input logic rw, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		int waited;
		waited = 0;
		@(negedge clock);
		i_data_request = 1'b1;
		i_data_rw = rw;
		i_data_address = addr;
		i_data_wdata = wdata;
		while (!o_data_ready)
		begin
			if (waited == BUS_TIMEOUT)
				abort_run("data port ready never came");
			@(negedge clock);
			waited++;
		end
		rdata = o_data_rdata;
		// Drop request the cycle after ready
		@(negedge clock);
		i_data_request = 1'b0;
		i_data_rw = ~BUS_WRITE;
	endtask

	task automatic data_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
		logic [DATA_W-1:0] unused;
		data_access(BUS_WRITE, addr, wdata, unused);
	endtask

	task automatic data_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
		data_access(~BUS_WRITE, addr, '0, rdata);
	endtask

	task automatic fetch_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
		int waited;
		waited = 0;
		@(negedge clock);
		i_fetch_request = 1'b1;
		i_fetch_address = addr;
		while (!o_fetch_ready)
		begin
			if (waited == BUS_TIMEOUT)
				abort_run("fetch port ready never came");
			@(negedge clock);
			waited++;
		end
		rdata = o_fetch_rdata;
		@(negedge clock);
		i_fetch_request = 1'b0;
	endtask

	function automatic logic [ADDR_W-1:0] ram_addr(input int index);
		logic [RAM_ADDR_W-1:0] word;
		word = index[RAM_ADDR_W-1:0];
		return {REGION_RAM, {(OFFSET_W-RAM_ADDR_W-BYTE_W){1'b0}}, word, {BYTE_W{1'b0}}};
	endfunction

	function automatic logic [ADDR_W-1:0] reg_addr(input logic [REGION_W-1:0] region,
		input logic [REG_IDX_W-1:0] index);
		return {region, {(OFFSET_W-REG_IDX_W-BYTE_W){1'b0}}, index, {BYTE_W{1'b0}}};
	endfunction

	// ====================
	// Tests
	// ====================
	task automatic test_reset();
		logic [DATA_W-1:0] rdata;
		repeat (RESET_CYCLES)
		begin
			@(negedge clock);
			check_value("o_data_ready", o_data_ready, 0);
			check_value("o_fetch_ready", o_fetch_ready, 0);
			check_value("o_interrupt", o_interrupt, 0);
		end
		i_rst_n = 1'b1;
		@(negedge clock);
		check_value("o_data_ready", o_data_ready, 0);
		check_value("o_fetch_ready", o_fetch_ready, 0);
		check_value("o_interrupt", o_interrupt, 0);
		data_read(reg_addr(REGION_DMA, DMA_REG_CTRL), rdata);
		check_value("DMA CTRL busy", rdata[0], 0);
		finish_test("Reset");
	endtask

	task automatic test_ram();
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] rdata;
		int index;
		for (int i = 0; i < 32; i++)
		begin
			index = $urandom % RAM_WORDS;
			wdata = $urandom;
			data_write(ram_addr(index), wdata);
			ram_model[index] = wdata;
			written_idx.push_back(index);
		end
		foreach (written_idx[i])
		begin
			data_read(ram_addr(written_idx[i]), rdata);
			check_value("o_data_rdata", rdata, ram_model[written_idx[i]]);
		end
		finish_test("RAM");
	endtask

	task automatic test_arbitration();
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] data_rdata;
		logic [DATA_W-1:0] fetch_rdata;
		time data_done;
		time fetch_done;
		int index;
		index = $urandom % RAM_WORDS;
		wdata = $urandom;
		// Data wins, so fetch sees the new word
		ram_model[index] = wdata;
		fork
			begin
				data_write(ram_addr(index), wdata);
				data_done = $time;
			end
			begin
				fetch_read(ram_addr(index), fetch_rdata);
				fetch_done = $time;
			end
		join
		check_value("o_fetch_rdata", fetch_rdata, wdata);
		if (data_done >= fetch_done)
			flag_violation("fetch finished before the data port on a shared request");
		fork
			begin
				data_read(ram_addr(written_idx[0]), data_rdata);
				data_done = $time;
			end
			begin
				fetch_read(ram_addr(written_idx[1]), fetch_rdata);
				fetch_done = $time;
			end
		join
		check_value("o_data_rdata", data_rdata, ram_model[written_idx[0]]);
		check_value("o_fetch_rdata", fetch_rdata, ram_model[written_idx[1]]);
		if (data_done >= fetch_done)
			flag_violation("fetch finished before the data port on a shared request");
		// Fetch alone on an idle bus
		fetch_read(ram_addr(written_idx[2]), fetch_rdata);
		check_value("o_fetch_rdata", fetch_rdata, ram_model[written_idx[2]]);
		finish_test("Arbitration");
	endtask

	task automatic test_unmapped();
		logic [DATA_W-1:0] rdata;
		data_read({4'hF, {OFFSET_W{1'b0}}}, rdata);
		check_value("o_data_rdata", rdata, 0);
		finish_test("Unmapped");
	endtask

	task automatic test_timer();
		logic [DATA_W-1:0] rdata;
		int compare;
		int waited;
		compare = 5 + $urandom % 36;
		data_write(reg_addr(REGION_TIMER, TMR_REG_COMPARE), compare);
		data_write(reg_addr(REGION_TIMER, TMR_REG_CTRL), 3);
		waited = 0;
		while (!o_interrupt && waited < compare + 3)
		begin
			@(negedge clock);
			waited++;
		end
		if (!o_interrupt)
			flag_violation("timer interrupt did not rise within compare + 3 cycles");
		data_read(reg_addr(REGION_TIMER, TMR_REG_STATUS), rdata);
		check_value("timer STATUS", rdata, 1);
		// Counter stopped, interrupt still unmasked
		data_write(reg_addr(REGION_TIMER, TMR_REG_CTRL), 2);
		check_value("o_interrupt", o_interrupt, 1);
		data_write(reg_addr(REGION_TIMER, TMR_REG_STATUS), 1);
		check_value("o_interrupt", o_interrupt, 0);
		data_write(reg_addr(REGION_TIMER, TMR_REG_CTRL), 0);
		finish_test("Timer");
	endtask

	task automatic test_dma();
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] rdata;
		int src_idx;
		int dst_idx;
		int polls;
		logic busy;
		// Source and destination never overlap
		src_idx = $urandom % 1024;
		dst_idx = 2048 + $urandom % 1024;
		for (int i = 0; i < 8; i++)
		begin
			wdata = $urandom;
			data_write(ram_addr(src_idx + i), wdata);
			ram_model[src_idx + i] = wdata;
		end
		data_write(reg_addr(REGION_DMA, DMA_REG_SRC), ram_addr(src_idx));
		data_write(reg_addr(REGION_DMA, DMA_REG_DST), ram_addr(dst_idx));
		data_write(reg_addr(REGION_DMA, DMA_REG_COUNT), 8);
		data_write(reg_addr(REGION_DMA, DMA_REG_CTRL), 1);
		latency_armed = 1'b0;
		polls = 0;
		busy = 1'b1;
		while (busy)
		begin
			if (polls == DMA_POLL_LIMIT)
				abort_run("DMA busy bit never cleared");
			// Idle gap lets the DMA win the bus
			repeat (4) @(negedge clock);
			data_read(reg_addr(REGION_DMA, DMA_REG_CTRL), rdata);
			busy = rdata[0];
			polls++;
		end
		latency_armed = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			data_read(ram_addr(dst_idx + i), rdata);
			check_value("DMA destination word", rdata, ram_model[src_idx + i]);
			data_read(ram_addr(src_idx + i), rdata);
			check_value("DMA source word", rdata, ram_model[src_idx + i]);
			ram_model[dst_idx + i] = ram_model[src_idx + i];
		end
		finish_test("DMA");
	endtask

	initial
	begin
		void'($urandom(SEED));
		i_rst_n = 1'b0;
		i_fetch_request = 1'b0;
		i_fetch_address = '0;
		i_data_request = 1'b0;
		i_data_rw = ~BUS_WRITE;
		i_data_address = '0;
		i_data_wdata = '0;
		latency_armed = 1'b1;
		error_count = 0;
		tests_run = 0;
		errors_at_start = 0;

		test_reset();
		test_ram();
		test_arbitration();
		test_unmapped();
		test_timer();
		test_dma();

		$display("%0d tests run, %0d errors", tests_run, error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* sources.f */
soc_pkg.sv
bus_interconnect.sv
block_ram.sv
dma_engine.sv
interval_timer.sv
soc_top.sv
tb_clock_gen.sv
tb_soc.sv
